//--- common/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] vram_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  tile_col_t;
    typedef logic [7:0]  pixel_x_t;
    typedef logic [1:0]  color_t;

    ////////////////////////////////////////////////////////////
    // Line and memory geometry
    ////////////////////////////////////////////////////////////

    localparam int SCREEN_W       = 160;
    localparam int TILE_PX        = 8;
    localparam int TILES_PER_LINE = 21;
    localparam int READ_CYCLES    = 2;
    localparam int VRAM_BYTES     = 8192;
    localparam int WX_OFFSET      = 7;

    localparam vram_addr_t MAP_LO_BASE        = 16'h9800;
    localparam vram_addr_t MAP_HI_BASE        = 16'h9C00;
    localparam vram_addr_t DATA_UNSIGNED_BASE = 16'h8000;
    localparam vram_addr_t DATA_SIGNED_BASE   = 16'h9000;
    localparam vram_addr_t VRAM_BASE          = 16'h8000;

    // LCD register snapshot, held for a whole line
    typedef struct packed {
        byte_t lcdc;
        byte_t scx;
        byte_t scy;
        byte_t ly;
        byte_t wx;
        byte_t wy;
    } lcd_regs_t;

    typedef struct packed {
        byte_t low;
        byte_t high;
    } tile_row_t;

    typedef struct packed {
        pixel_x_t x;
        color_t   color;
    } fifo_pixel_t;

    typedef enum logic [2:0] {idle, map_read, low_read, high_read, push, drain} fetch_state_t;

endpackage

//--- fetcher/tile_addr_gen.sv
`timescale 1ns/1ns

module tile_addr_gen (
    input  fetch_pkg::lcd_regs_t  regs,
    input  fetch_pkg::tile_col_t  col,
    input  fetch_pkg::byte_t      tile_num,
    output fetch_pkg::vram_addr_t map_addr,
    output fetch_pkg::vram_addr_t data_addr
);

    logic [8:0]            win_x;
    logic [7:0]            col_px;
    logic                  in_win;
    logic [4:0]            map_col;
    fetch_pkg::byte_t      map_row;
    fetch_pkg::vram_addr_t map_base;
    fetch_pkg::vram_addr_t data_base;
    fetch_pkg::vram_addr_t tile_off;

    ////////////////////////////////////////////////////////////
    // Window or background selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        // wx below the offset wraps high, so the window never opens
        win_x  = {1'b0, regs.wx} - 9'(fetch_pkg::WX_OFFSET);
        col_px = 8'(col * fetch_pkg::TILE_PX);
        in_win = regs.lcdc[5] && (regs.wy <= regs.ly) && (win_x <= {1'b0, col_px});

        if (in_win) begin
            map_col  = col - 5'(win_x >> 3);
            map_row  = regs.ly - regs.wy;
            map_base = regs.lcdc[6] ? fetch_pkg::MAP_HI_BASE : fetch_pkg::MAP_LO_BASE;
        end else begin
            // Coarse scroll wraps inside the 32-tile map
            map_col  = 5'(regs.scx >> 3) + col;
            map_row  = regs.scy + regs.ly;
            map_base = regs.lcdc[3] ? fetch_pkg::MAP_HI_BASE : fetch_pkg::MAP_LO_BASE;
        end
    end

    assign map_addr = map_base + {6'b0, map_row[7:3], map_col};

    ////////////////////////////////////////////////////////////
    // Tile data address
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (regs.lcdc[4]) begin
            data_base = fetch_pkg::DATA_UNSIGNED_BASE;
            tile_off  = {4'b0, tile_num, 4'b0};
        end else begin
            // Signed tile numbers reach down to 0x8800
            data_base = fetch_pkg::DATA_SIGNED_BASE;
            tile_off  = {{4{tile_num[7]}}, tile_num, 4'b0};
        end
    end

    assign data_addr = data_base + tile_off + {12'b0, map_row[2:0], 1'b0};

endmodule

//--- fetcher/fetch_fsm.sv
`timescale 1ns/1ns

module fetch_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  fifo_empty,
    input  logic                  bg_en,
    input  fetch_pkg::byte_t      vram_dout,
    input  logic                  ready,
    input  fetch_pkg::vram_addr_t map_addr,
    input  fetch_pkg::vram_addr_t data_addr,
    output fetch_pkg::tile_col_t  col,
    output fetch_pkg::byte_t      tile_num,
    output fetch_pkg::vram_addr_t vram_a,
    output logic                  row_load,
    output fetch_pkg::tile_row_t  row,
    output fetch_pkg::tile_col_t  row_col,
    output logic                  done
);

    fetch_pkg::fetch_state_t state;
    logic [1:0]              cyc;
    logic                    last_cyc;
    fetch_pkg::byte_t        low_q;
    fetch_pkg::byte_t        high_q;
    logic                    last_col;

    assign last_cyc = (cyc == 2'(fetch_pkg::READ_CYCLES - 1));
    assign last_col = (col == fetch_pkg::tile_col_t'(fetch_pkg::TILES_PER_LINE - 1));

    // Address stays put for the whole read state
    always_comb begin
        case (state)
            fetch_pkg::low_read:  vram_a = data_addr;
            fetch_pkg::high_read: vram_a = data_addr + 16'd1;
            default:              vram_a = map_addr;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::idle;
            cyc      <= '0;
            col      <= '0;
            row_load <= 1'b0;
            done     <= 1'b0;
        end else if (start) begin
            // Restart the line from column 0
            state    <= fetch_pkg::map_read;
            cyc      <= '0;
            col      <= '0;
            row_load <= 1'b0;
            done     <= 1'b0;
        end else begin
            row_load <= 1'b0;
            done     <= 1'b0;
            case (state)
                fetch_pkg::map_read,
                fetch_pkg::low_read,
                fetch_pkg::high_read: begin
                    if (last_cyc) begin
                        cyc <= '0;
                        if (state == fetch_pkg::map_read) begin
                            state <= fetch_pkg::low_read;
                        end else if (state == fetch_pkg::low_read) begin
                            state <= fetch_pkg::high_read;
                        end else begin
                            state <= fetch_pkg::push;
                        end
                    end else begin
                        cyc <= cyc + 2'd1;
                    end
                end
                fetch_pkg::push: begin
                    if (fifo_empty && ready) begin
                        row_load <= 1'b1;
                        if (last_col) begin
                            state <= fetch_pkg::drain;
                        end else begin
                            col   <= col + 5'd1;
                            state <= fetch_pkg::map_read;
                        end
                    end
                end
                fetch_pkg::drain: begin
                    // Wait until the serializer has taken and sent the last row
                    if (ready && !row_load) begin
                        done  <= 1'b1;
                        state <= fetch_pkg::idle;
                    end
                end
                default: begin
                    state <= fetch_pkg::idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Captured bytes and issued row
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (last_cyc) begin
            case (state)
                fetch_pkg::map_read:  tile_num <= vram_dout;
                fetch_pkg::low_read:  low_q    <= vram_dout;
                fetch_pkg::high_read: high_q   <= vram_dout;
                default: ;
            endcase
        end
        if (state == fetch_pkg::push && fifo_empty && ready) begin
            row.low  <= bg_en ? low_q : 8'h00;
            row.high <= bg_en ? high_q : 8'h00;
            row_col  <= col;
        end
    end

    // Serializer must still be idle on the cycle the row arrives
    a_load_when_ready: assert property (@(posedge clk) disable iff (rst) row_load |-> ready)
        else $error("row_load while serializer busy");

endmodule

//--- fetcher/pixel_serializer.sv
`timescale 1ns/1ns

module pixel_serializer (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::lcd_regs_t   regs,
    input  logic                   row_load,
    input  fetch_pkg::tile_row_t   row,
    input  fetch_pkg::tile_col_t   row_col,
    output logic                   ready,
    output logic                   fifo_write,
    output fetch_pkg::fifo_pixel_t fifo_pixel
);

    fetch_pkg::tile_row_t row_q;
    logic                 busy;
    logic [2:0]           idx;
    logic [2:0]           last_idx;
    logic [2:0]           first_idx;
    logic [2:0]           load_last;
    logic                 load_empty;
    fetch_pkg::pixel_x_t  x_next;
    fetch_pkg::pixel_x_t  load_x;
    logic                 first_col;
    logic                 final_col;

    // Leftmost pixel sits in bit 7
    function automatic fetch_pkg::color_t pick(input fetch_pkg::tile_row_t r,
                                               input logic [2:0] k);
        return {r.high[3'd7 - k], r.low[3'd7 - k]};
    endfunction

    always_comb begin
        first_col  = (row_col == '0);
        final_col  = (row_col == fetch_pkg::tile_col_t'(fetch_pkg::TILES_PER_LINE - 1));
        first_idx  = first_col ? regs.scx[2:0] : 3'd0;
        load_last  = final_col ? regs.scx[2:0] - 3'd1 : 3'd7;
        load_empty = final_col && (regs.scx[2:0] == 3'd0);
        load_x     = first_col ? '0 : x_next;
    end

    assign ready = !busy;

    ////////////////////////////////////////////////////////////
    // Write strobe and line position
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            fifo_write <= 1'b0;
            x_next     <= '0;
        end else begin
            fifo_write <= 1'b0;
            if (row_load && !load_empty) begin
                fifo_write <= 1'b1;
                x_next     <= load_x + 8'd1;
                busy       <= (first_idx != load_last);
            end else if (busy) begin
                fifo_write <= 1'b1;
                x_next     <= x_next + 8'd1;
                busy       <= (idx != last_idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_load) begin
            row_q            <= row;
            idx              <= first_idx + 3'd1;
            last_idx         <= load_last;
            fifo_pixel.x     <= load_x;
            fifo_pixel.color <= pick(row, first_idx);
        end else if (busy) begin
            idx              <= idx + 3'd1;
            fifo_pixel.x     <= x_next;
            fifo_pixel.color <= pick(row_q, idx);
        end
    end

    a_x_on_screen: assert property (@(posedge clk) disable iff (rst)
        fifo_write |-> (fifo_pixel.x < fetch_pkg::pixel_x_t'(fetch_pkg::SCREEN_W)))
        else $error("pixel x off screen: %0d", fifo_pixel.x);

endmodule

//--- fetcher/bg_fetcher.sv
`timescale 1ns/1ns

module bg_fetcher (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  fetch_pkg::lcd_regs_t   regs,
    input  fetch_pkg::byte_t       vram_dout,
    output fetch_pkg::vram_addr_t  vram_a,
    input  logic                   fifo_empty,
    output logic                   fifo_write,
    output fetch_pkg::fifo_pixel_t fifo_pixel,
    output logic                   done
);

    fetch_pkg::tile_col_t  col;
    fetch_pkg::byte_t      tile_num;
    fetch_pkg::vram_addr_t map_addr;
    fetch_pkg::vram_addr_t data_addr;
    logic                  row_load;
    fetch_pkg::tile_row_t  row;
    fetch_pkg::tile_col_t  row_col;
    logic                  ready;

    tile_addr_gen u_addr (
        .regs      (regs),
        .col       (col),
        .tile_num  (tile_num),
        .map_addr  (map_addr),
        .data_addr (data_addr)
    );

    fetch_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .fifo_empty (fifo_empty),
        .bg_en      (regs.lcdc[0]),
        .vram_dout  (vram_dout),
        .ready      (ready),
        .map_addr   (map_addr),
        .data_addr  (data_addr),
        .col        (col),
        .tile_num   (tile_num),
        .vram_a     (vram_a),
        .row_load   (row_load),
        .row        (row),
        .row_col    (row_col),
        .done       (done)
    );

    pixel_serializer u_ser (
        .clk        (clk),
        .rst        (rst),
        .regs       (regs),
        .row_load   (row_load),
        .row        (row),
        .row_col    (row_col),
        .ready      (ready),
        .fifo_write (fifo_write),
        .fifo_pixel (fifo_pixel)
    );

endmodule

//--- dv/vram_model.sv
`timescale 1ns/1ns

module vram_model (
    input  logic                  clk,
    input  fetch_pkg::vram_addr_t addr,
    output fetch_pkg::byte_t      dout
);

    localparam int ADDR_BITS = $clog2(fetch_pkg::VRAM_BYTES);

    // Written directly by the testbench between lines
    fetch_pkg::byte_t      mem [0:fetch_pkg::VRAM_BYTES-1];
    fetch_pkg::vram_addr_t offset;

    // Addresses outside the 8 KB window alias onto it
    assign offset = addr - fetch_pkg::VRAM_BASE;

    always_ff @(posedge clk) begin
        dout <= mem[offset[ADDR_BITS-1:0]];
    end

endmodule

//--- dv/tb_bg_fetcher.sv
`timescale 1ns/1ns

module tb_bg_fetcher;

    localparam int LINES           = 40;
    localparam int WATCHDOG_CYCLES = LINES * fetch_pkg::TILES_PER_LINE * 40;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   fifo_empty = 1'b1;
    fetch_pkg::lcd_regs_t   regs;
    fetch_pkg::byte_t       vram_dout;
    fetch_pkg::vram_addr_t  vram_a;
    logic                   fifo_write;
    fetch_pkg::fifo_pixel_t fifo_pixel;
    logic                   done;

    int                     seed;
    int                     pix_count;
    bit                     done_seen;
    fetch_pkg::fifo_pixel_t expected [$];

    bg_fetcher UUT (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .regs       (regs),
        .vram_dout  (vram_dout),
        .vram_a     (vram_a),
        .fifo_empty (fifo_empty),
        .fifo_write (fifo_write),
        .fifo_pixel (fifo_pixel),
        .done       (done)
    );

    vram_model u_vram (
        .clk  (clk),
        .addr (vram_a),
        .dout (vram_dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic fetch_pkg::byte_t vram_byte(input int addr);
        return u_vram.mem[13'(addr - int'(fetch_pkg::VRAM_BASE))];
    endfunction

    ////////////////////////////////////////////////////////////
    // Line model
    ////////////////////////////////////////////////////////////

    task automatic build_expected(input fetch_pkg::lcd_regs_t r);
        int win_left;
        int map_col;
        int map_row;
        int map_base;
        int data;
        int first;
        int last;
        int x;
        fetch_pkg::byte_t       tile;
        fetch_pkg::byte_t       low;
        fetch_pkg::byte_t       high;
        fetch_pkg::fifo_pixel_t p;
        expected.delete();
        x = 0;
        win_left = int'(r.wx) - fetch_pkg::WX_OFFSET;
        for (int c = 0; c < fetch_pkg::TILES_PER_LINE; c++) begin
            if (r.lcdc[5] && r.wy <= r.ly && win_left >= 0 && win_left <= c * 8) begin
                map_col  = c - win_left / 8;
                map_row  = int'(r.ly) - int'(r.wy);
                map_base = r.lcdc[6] ? int'(fetch_pkg::MAP_HI_BASE) : int'(fetch_pkg::MAP_LO_BASE);
            end else begin
                map_col  = (int'(r.scx) / 8 + c) % 32;
                map_row  = (int'(r.scy) + int'(r.ly)) % 256;
                map_base = r.lcdc[3] ? int'(fetch_pkg::MAP_HI_BASE) : int'(fetch_pkg::MAP_LO_BASE);
            end
            tile = vram_byte(map_base + map_col + (map_row / 8) * 32);
            if (r.lcdc[4]) begin
                data = int'(fetch_pkg::DATA_UNSIGNED_BASE) + int'(tile) * 16;
            end else begin
                data = int'(fetch_pkg::DATA_SIGNED_BASE) + int'(signed'(tile)) * 16;
            end
            data = data + (map_row % 8) * 2;
            low  = r.lcdc[0] ? vram_byte(data) : 8'h00;
            high = r.lcdc[0] ? vram_byte(data + 1) : 8'h00;
            // Fine scroll trims both ends of the line
            first = (c == 0) ? int'(r.scx[2:0]) : 0;
            last  = (c == fetch_pkg::TILES_PER_LINE - 1) ? int'(r.scx[2:0]) - 1 : 7;
            for (int k = first; k <= last; k++) begin
                p.x     = 8'(x);
                p.color = {high[3'(7 - k)], low[3'(7 - k)]};
                expected.push_back(p);
                x++;
            end
        end
    endtask

    task automatic pick_regs(input int line, output fetch_pkg::lcd_regs_t r);
        r.lcdc = 8'($random(seed));
        r.scx  = 8'($random(seed));
        r.scy  = 8'($random(seed));
        r.ly   = 8'({$random(seed)} % 144);
        r.wy   = 8'({$random(seed)} % 144);
        r.wx   = 8'(fetch_pkg::WX_OFFSET + {$random(seed)} % 160);
        // Steer some lines toward background, window and signed data
        r.lcdc[0] = 1'b1;
        case (line % 4)
            0: r.lcdc[5] = 1'b0;
            1: begin
                r.lcdc[5] = 1'b1;
                r.wy      = r.ly >> 1;
            end
            2: r.lcdc[4] = 1'b0;
            default: r.lcdc[0] = (line % 8 != 3);
        endcase
    endtask

    // Random FIFO back-pressure
    always @(posedge clk) begin
        fifo_empty <= ({$random(seed)} % 4) != 0;
    end

    ////////////////////////////////////////////////////////////
    // Output checks
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && fifo_write) begin
            assert (!done_seen)
                else stop_run("fifo write outside an active line");
            assert (pix_count < fetch_pkg::SCREEN_W)
                else stop_run("too many pixels written in one line");
            assert (fifo_pixel == expected[pix_count])
                else stop_run($sformatf("error: fifo_pixel = %h, expected %h",
                                        fifo_pixel, expected[pix_count]));
            pix_count++;
        end
        if (!rst && done) begin
            assert (!done_seen)
                else stop_run("done pulsed more than once in one line");
            assert (pix_count == fetch_pkg::SCREEN_W)
                else stop_run($sformatf("line ended after %0d pixels", pix_count));
            done_seen = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("watchdog timeout, the lines did not finish in time");
    end

    initial begin
        fetch_pkg::lcd_regs_t r;
        seed      = 91;
        rst       = 1'b1;
        start     = 1'b0;
        regs      = '0;
        pix_count = 0;
        done_seen = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int line = 0; line < LINES; line++) begin
            @(negedge clk);
            pick_regs(line, r);
            for (int i = 0; i < fetch_pkg::VRAM_BYTES; i++) begin
                u_vram.mem[13'(i)] = 8'($random(seed));
            end
            build_expected(r);
            @(posedge clk);
            regs      <= r;
            start     <= 1'b1;
            pix_count = 0;
            done_seen = 1'b0;
            @(posedge clk);
            start <= 1'b0;
            wait (done_seen);
            // Any write in this gap is caught by the checks
            repeat (4) @(posedge clk);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb.f
common/fetch_pkg.sv
fetcher/tile_addr_gen.sv
fetcher/fetch_fsm.sv
fetcher/pixel_serializer.sv
fetcher/bg_fetcher.sv
dv/vram_model.sv
dv/tb_bg_fetcher.sv

//--- Makefile
SRCS = $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/Vtb_bg_fetcher
	@out=$$(./obj_dir/Vtb_bg_fetcher); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

obj_dir/Vtb_bg_fetcher: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_bg_fetcher -f tb.f

clean:
	rm -rf obj_dir
